//--- dv/dispatch_asserts.sv
// Protocol checks bound into the dispatch top level.
// Covers reset quiet, hazard gating and output hold under downstream stall.
`timescale 1ns/100ps

module dispatch_asserts (
    input logic                         clk,
    input logic                         rst_n_i,
    input logic                         stall_i,
    input logic                         inst_valid_i,
    input logic                         hazard_stall_o,
    input dispatch_bus_pkg::issue_t     issue_o,
    input dispatch_bus_pkg::alu_req_t   alu_o,
    input dispatch_bus_pkg::bjp_req_t   bjp_o,
    input dispatch_bus_pkg::mem_req_t   mem_o
);

    logic quiet;

    // nothing issued and no flag raised
    assign quiet = !issue_o.valid && !alu_o.req && !bjp_o.req && !mem_o.req &&
                   !mem_o.misaligned_load && !mem_o.misaligned_store;

    reset_quiet: assert property (@(posedge clk) !rst_n_i |=> quiet)
        else $error("outputs active during reset");

    reset_release_quiet: assert property (@(posedge clk) $rose(rst_n_i) |-> quiet)
        else $error("outputs active right after reset");

    reset_no_stall: assert property (@(posedge clk) !rst_n_i |-> !hazard_stall_o)
        else $error("hazard stall raised during reset");

    no_accept_on_hazard: assert property (@(posedge clk) disable iff (!rst_n_i)
        hazard_stall_o |=> quiet)
        else $error("instruction issued while hazard stall was high");

    accept_issues: assert property (@(posedge clk) disable iff (!rst_n_i)
        (inst_valid_i && !stall_i && !hazard_stall_o) |=> issue_o.valid)
        else $error("accepted instruction did not issue");

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> ($stable(issue_o) && $stable(alu_o) && $stable(bjp_o) && $stable(mem_o)))
        else $error("outputs changed under downstream stall");

    misaligned_no_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_o.misaligned_load || mem_o.misaligned_store) |-> !mem_o.req)
        else $error("misaligned access raised a memory request");

endmodule

bind dispatch dispatch_asserts u_dispatch_asserts (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .stall_i        (stall_i),
    .inst_valid_i   (inst_valid_i),
    .hazard_stall_o (hazard_stall_o),
    .issue_o        (issue_o),
    .alu_o          (alu_o),
    .bjp_o          (bjp_o),
    .mem_o          (mem_o)
);

//--- dv/dispatch_tb.sv
// Testbench for the dispatch stage: drives decoded instructions and checks the issued requests.
// Expected values come from a reference model of the dispatch rules.
`timescale 1ns/100ps
`include "dispatch_settings.svh"

module dispatch_tb;

    localparam int PERIOD      = 4;
    localparam int STIM_CYCLES = 10 + 40 * 3 + 8 * 3 + 32 * 3 + 40 + 20;

    logic                           clk;
    logic                           rst_n_i;
    logic                           stall_i;
    logic                           inst_valid_i;
    dispatch_bus_pkg::dec_bus_t     dec_i;
    logic [`DISP_XLEN-1:0]          rs1_rdata_i;
    logic [`DISP_XLEN-1:0]          rs2_rdata_i;
    logic                           commit_valid_i;
    logic [`DISP_COMMIT_ID_W-1:0]   commit_id_i;
    logic                           hazard_stall_o;
    dispatch_bus_pkg::issue_t       issue_o;
    dispatch_bus_pkg::alu_req_t     alu_o;
    dispatch_bus_pkg::bjp_req_t     bjp_o;
    dispatch_bus_pkg::mem_req_t     mem_o;

    dispatch DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // run length bound
    initial begin
        #(20 * STIM_CYCLES * PERIOD);
        $display("timeout: the dispatch stage stopped making progress");
        $display("TESTS FAILED");
        $fatal(1);
    end

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        assert (exp === act) else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    function automatic dispatch_bus_pkg::alu_req_t model_alu(
        input dispatch_bus_pkg::dec_bus_t d, input logic [31:0] r1, input logic [31:0] r2);
        dispatch_bus_pkg::alu_req_t m;
        m.req = 1'b1;
        m.op  = dispatch_isa_pkg::alu_op_e'(d.info.op);
        m.op1 = d.info.op1_pc ? d.pc : r1;
        m.op2 = d.info.op2_imm ? d.imm : r2;
        return m;
    endfunction

    function automatic dispatch_bus_pkg::bjp_req_t model_bjp(
        input dispatch_bus_pkg::dec_bus_t d, input logic [31:0] r1, input logic [31:0] r2);
        dispatch_bus_pkg::bjp_req_t m;
        m.req          = 1'b1;
        m.op           = dispatch_isa_pkg::bjp_op_e'(d.info.op[2:0]);
        m.adder_result = (m.op == dispatch_isa_pkg::BJP_JALR) ? r1 + d.imm : d.pc + d.imm;
        m.next_pc      = d.pc + 32'd4;
        m.eq           = (r1 == r2);
        m.ge_signed    = ($signed(r1) >= $signed(r2));
        m.ge_unsigned  = (r1 >= r2);
        return m;
    endfunction

    function automatic dispatch_bus_pkg::mem_req_t model_mem(
        input dispatch_bus_pkg::dec_bus_t d, input logic [31:0] r1, input logic [31:0] r2);
        dispatch_bus_pkg::mem_req_t m;
        logic [3:0] lanes;
        logic       mis;
        logic       store;
        m.op   = dispatch_isa_pkg::mem_op_e'(d.info.op[2:0]);
        m.addr = r1 + d.imm;
        store  = (d.info.op[2:0] >= 3'd5);
        lanes  = (m.op == dispatch_isa_pkg::MEM_SB) ? 4'b0001 :
                 (m.op == dispatch_isa_pkg::MEM_SH) ? 4'b0011 :
                 (m.op == dispatch_isa_pkg::MEM_SW) ? 4'b1111 : 4'b0000;
        // halfwords need even, words need four-byte alignment
        mis = ((m.op inside {dispatch_isa_pkg::MEM_LH, dispatch_isa_pkg::MEM_LHU,
                             dispatch_isa_pkg::MEM_SH}) && m.addr[0]) ||
              ((m.op inside {dispatch_isa_pkg::MEM_LW, dispatch_isa_pkg::MEM_SW}) &&
               (m.addr[1:0] != 2'b00));
        m.wmask            = lanes << m.addr[1:0];
        m.wdata            = r2 << {m.addr[1:0], 3'b000};
        m.req              = !mis;
        m.misaligned_load  = mis && !store;
        m.misaligned_store = mis && store;
        return m;
    endfunction

    // random payload with no register dependencies
    function automatic dispatch_bus_pkg::dec_bus_t rand_dec(
        input dispatch_isa_pkg::unit_e unit, input logic [3:0] op);
        dispatch_bus_pkg::dec_bus_t d;
        d.info.unit    = unit;
        d.info.op      = op;
        d.info.op1_pc  = 1'b0;
        d.info.op2_imm = 1'b0;
        d.imm          = $urandom;
        d.pc           = $urandom & 32'hFFFF_FFFC;
        d.rs1_addr     = 5'($urandom);
        d.rs1_re       = 1'b0;
        d.rs2_addr     = 5'($urandom);
        d.rs2_re       = 1'b0;
        d.rd_addr      = 5'($urandom);
        d.rd_we        = 1'b0;
        return d;
    endfunction

    // drive, wait out any hazard, then return one edge after the accept
    task automatic send(input dispatch_bus_pkg::dec_bus_t d, input logic [31:0] r1,
                        input logic [31:0] r2);
        dec_i        = d;
        rs1_rdata_i  = r1;
        rs2_rdata_i  = r2;
        inst_valid_i = 1'b1;
        @(negedge clk);
        while (hazard_stall_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
    endtask

    task automatic check_issue(input string name, input dispatch_bus_pkg::dec_bus_t d,
                               input logic [1:0] id);
        check({name, ".issue"}, 128'({1'b1, d.pc, id, d.rd_addr, d.rd_we}), 128'(issue_o));
    endtask

    initial begin
        dispatch_bus_pkg::dec_bus_t d;
        dispatch_bus_pkg::dec_bus_t held;
        dispatch_bus_pkg::mem_req_t exp_mem;
        logic [31:0] r1;
        logic [31:0] r2;
        void'($urandom(21973));
        rst_n_i        = 1'b0;
        stall_i        = 1'b0;
        inst_valid_i   = 1'b0;
        dec_i          = '0;
        rs1_rdata_i    = '0;
        rs2_rdata_i    = '0;
        commit_valid_i = 1'b0;
        commit_id_i    = '0;
        repeat (2) @(posedge clk);
        #1;

        // a valid load during reset must neither issue nor allocate
        d            = rand_dec(dispatch_isa_pkg::UNIT_MEM, 4'(dispatch_isa_pkg::MEM_LW));
        d.imm        = '0;
        d.rs1_addr   = 5'd1;
        d.rs1_re     = 1'b1;
        d.rd_addr    = 5'd1;
        d.rd_we      = 1'b1;
        dec_i        = d;
        inst_valid_i = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
        rst_n_i      = 1'b1;

        for (int i = 0; i < 40; i++) begin
            d = rand_dec(dispatch_isa_pkg::UNIT_ALU, 4'($urandom_range(0, 9)));
            d.info.op1_pc  = i[0];
            d.info.op2_imm = i[1];
            r1 = $urandom;
            r2 = $urandom;
            send(d, r1, r2);
            check("alu", 128'(model_alu(d, r1, r2)), 128'(alu_o));
            check_issue("alu", d, 2'd0);
        end

        for (int i = 0; i < 8; i++) begin
            d  = rand_dec(dispatch_isa_pkg::UNIT_BJP, 4'(i));
            r1 = $urandom;
            r2 = i[0] ? r1 : $urandom;
            send(d, r1, r2);
            check("bjp", 128'(model_bjp(d, r1, r2)), 128'(bjp_o));
            check("bjp.others", 128'({alu_o.req, mem_o.req}), 128'(0));
        end

        // loads write back, so aligned ones take entry 0 and misaligned ones take none
        for (int i = 0; i < 32; i++) begin
            d         = rand_dec(dispatch_isa_pkg::UNIT_MEM, 4'(i / 4));
            d.imm     = 32'(i % 4);
            d.rd_addr = 5'(i + 1);
            d.rd_we   = (i < 20);
            r1        = $urandom & 32'hFFFF_FFFC;
            r2        = $urandom;
            exp_mem   = model_mem(d, r1, r2);
            send(d, r1, r2);
            check("mem", 128'(exp_mem), 128'(mem_o));
            check_issue("mem", d, 2'd0);
            if (d.rd_we && exp_mem.req) begin
                commit_valid_i = 1'b1;
                commit_id_i    = 2'd0;
                @(posedge clk);
                #1;
                commit_valid_i = 1'b0;
            end
        end

        // fill the scoreboard with word loads to x1..x4
        for (int i = 0; i < 4; i++) begin
            d         = rand_dec(dispatch_isa_pkg::UNIT_MEM, 4'(dispatch_isa_pkg::MEM_LW));
            d.imm     = '0;
            d.rd_addr = 5'(i + 1);
            d.rd_we   = 1'b1;
            send(d, 32'h100, 32'h0);
            check_issue("load_id", d, 2'(i));
        end

        d.rd_addr    = 5'd5;
        dec_i        = d;
        inst_valid_i = 1'b1;
        @(negedge clk);
        check("full_stall", 128'(1), 128'(hazard_stall_o));
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;

        d              = rand_dec(dispatch_isa_pkg::UNIT_ALU, 4'(dispatch_isa_pkg::ALU_ADD));
        d.rs1_addr     = 5'd2;
        d.rs1_re       = 1'b1;
        r1             = $urandom;
        r2             = $urandom;
        dec_i          = d;
        rs1_rdata_i    = r1;
        rs2_rdata_i    = r2;
        inst_valid_i   = 1'b1;
        @(negedge clk);
        check("raw_stall", 128'(1), 128'(hazard_stall_o));
        @(posedge clk);
        #1;
        commit_valid_i = 1'b1;
        commit_id_i    = 2'd1;
        @(posedge clk);
        #1;
        commit_valid_i = 1'b0;
        send(d, r1, r2);
        check("raw_release", 128'(model_alu(d, r1, r2)), 128'(alu_o));
        check_issue("raw_release", d, 2'd0);

        // the freed entry is the lowest one again
        d         = rand_dec(dispatch_isa_pkg::UNIT_MEM, 4'(dispatch_isa_pkg::MEM_LW));
        d.imm     = '0;
        d.rd_addr = 5'd7;
        d.rd_we   = 1'b1;
        send(d, 32'h200, 32'h0);
        check_issue("realloc", d, 2'd1);

        held = rand_dec(dispatch_isa_pkg::UNIT_ALU, 4'(dispatch_isa_pkg::ALU_XOR));
        send(held, 32'h11, 32'h22);
        d            = rand_dec(dispatch_isa_pkg::UNIT_ALU, 4'(dispatch_isa_pkg::ALU_OR));
        r1           = $urandom;
        r2           = $urandom;
        stall_i      = 1'b1;
        dec_i        = d;
        rs1_rdata_i  = r1;
        rs2_rdata_i  = r2;
        inst_valid_i = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        check_issue("stall_hold", held, 2'd0);
        stall_i = 1'b0;
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
        check("stall_release", 128'(model_alu(d, r1, r2)), 128'(alu_o));
        check_issue("stall_release", d, 2'd0);
        @(posedge clk);
        #1;
        check("no_duplicate", 128'(0), 128'(issue_o.valid));

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
logic/dispatch_isa_pkg.sv
logic/dispatch_bus_pkg.sv
logic/dispatch_logic.sv
logic/dispatch_hdu.sv
logic/dispatch_pipe.sv
logic/dispatch.sv
dv/dispatch_asserts.sv
dv/dispatch_tb.sv

//--- logic/dispatch.sv
// Dispatch stage top: decode logic, load hazard unit and output register.
// Accepts one instruction per cycle and issues it one cycle later.
`timescale 1ns/100ps
`include "dispatch_settings.svh"

module dispatch (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            stall_i,
    input  logic                            inst_valid_i,
    input  dispatch_bus_pkg::dec_bus_t      dec_i,
    input  logic [`DISP_XLEN-1:0]           rs1_rdata_i,
    input  logic [`DISP_XLEN-1:0]           rs2_rdata_i,
    input  logic                            commit_valid_i,
    input  logic [`DISP_COMMIT_ID_W-1:0]    commit_id_i,
    output logic                            hazard_stall_o,
    output dispatch_bus_pkg::issue_t        issue_o,
    output dispatch_bus_pkg::alu_req_t      alu_o,
    output dispatch_bus_pkg::bjp_req_t      bjp_o,
    output dispatch_bus_pkg::mem_req_t      mem_o
);

    logic                           accept;
    logic                           is_long;
    logic [`DISP_COMMIT_ID_W-1:0]   alloc_id;
    dispatch_bus_pkg::alu_req_t     logic_alu;
    dispatch_bus_pkg::bjp_req_t     logic_bjp;
    dispatch_bus_pkg::mem_req_t     logic_mem;

    // hazard gating happens inside the hdu
    assign accept = inst_valid_i && !stall_i;

    dispatch_logic u_dispatch_logic (
        .dec_i       (dec_i),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .alu_o       (logic_alu),
        .bjp_o       (logic_bjp),
        .mem_o       (logic_mem),
        .is_long_o   (is_long)
    );

    dispatch_hdu u_dispatch_hdu (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .accept_i       (accept),
        .dec_i          (dec_i),
        .is_long_i      (is_long),
        .commit_valid_i (commit_valid_i),
        .commit_id_i    (commit_id_i),
        .hazard_stall_o (hazard_stall_o),
        .alloc_id_o     (alloc_id)
    );

    dispatch_pipe u_dispatch_pipe (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .inst_valid_i (inst_valid_i),
        .hazard_i     (hazard_stall_o),
        .dec_i        (dec_i),
        .alloc_id_i   (alloc_id),
        .alu_i        (logic_alu),
        .bjp_i        (logic_bjp),
        .mem_i        (logic_mem),
        .issue_o      (issue_o),
        .alu_o        (alu_o),
        .bjp_o        (bjp_o),
        .mem_o        (mem_o)
    );

endmodule

//--- logic/dispatch_bus_pkg.sv
// Structs passed between the dispatch modules and at the top-level ports.
// Sizes come from the settings header, encodings from the ISA package.
`include "dispatch_settings.svh"

package dispatch_bus_pkg;

    // one decoded instruction as presented by the decode stage
    typedef struct packed {
        dispatch_isa_pkg::dec_info_t    info;
        logic [`DISP_XLEN-1:0]          imm;
        logic [`DISP_XLEN-1:0]          pc;
        logic [`DISP_REG_ADDR_W-1:0]    rs1_addr;
        logic                           rs1_re;
        logic [`DISP_REG_ADDR_W-1:0]    rs2_addr;
        logic                           rs2_re;
        logic [`DISP_REG_ADDR_W-1:0]    rd_addr;
        logic                           rd_we;
    } dec_bus_t;

    typedef struct packed {
        logic                           req;
        dispatch_isa_pkg::alu_op_e      op;
        logic [`DISP_XLEN-1:0]          op1;
        logic [`DISP_XLEN-1:0]          op2;
    } alu_req_t;

    // compare flags are rs1 against rs2
    typedef struct packed {
        logic                           req;
        dispatch_isa_pkg::bjp_op_e      op;
        logic [`DISP_XLEN-1:0]          adder_result;
        logic [`DISP_XLEN-1:0]          next_pc;
        logic                           eq;
        logic                           ge_signed;
        logic                           ge_unsigned;
    } bjp_req_t;

    typedef struct packed {
        logic                           req;
        dispatch_isa_pkg::mem_op_e      op;
        logic [`DISP_XLEN-1:0]          addr;
        logic [`DISP_XLEN/8-1:0]        wmask;
        logic [`DISP_XLEN-1:0]          wdata;
        logic                           misaligned_load;
        logic                           misaligned_store;
    } mem_req_t;

    // record of the instruction leaving dispatch
    typedef struct packed {
        logic                           valid;
        logic [`DISP_XLEN-1:0]          pc;
        logic [`DISP_COMMIT_ID_W-1:0]   commit_id;
        logic [`DISP_REG_ADDR_W-1:0]    rd;
        logic                           we;
    } issue_t;

endpackage

//--- logic/dispatch_hdu.sv
// Hazard detection: scoreboard of outstanding loads with commit id allocation.
// Stalls any instruction touching a pending rd, frees entries on write-back commit.
`timescale 1ns/100ps
`include "dispatch_settings.svh"

module dispatch_hdu (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            accept_i,
    input  dispatch_bus_pkg::dec_bus_t      dec_i,
    input  logic                            is_long_i,
    input  logic                            commit_valid_i,
    input  logic [`DISP_COMMIT_ID_W-1:0]    commit_id_i,
    output logic                            hazard_stall_o,
    output logic [`DISP_COMMIT_ID_W-1:0]    alloc_id_o
);

    localparam int DEPTH = `DISP_SB_DEPTH;
    localparam int ID_W  = `DISP_COMMIT_ID_W;

    logic [DEPTH-1:0]               sb_valid;
    logic [`DISP_REG_ADDR_W-1:0]    sb_rd [DEPTH];
    logic                           reg_hit;
    logic                           sb_full;
    logic                           alloc;

    // x0 is never a dependency
    function automatic logic reg_match(
        input logic                         en,
        input logic [`DISP_REG_ADDR_W-1:0]  addr,
        input logic [`DISP_REG_ADDR_W-1:0]  entry
    );
        return en && (addr != '0) && (addr == entry);
    endfunction

    // any source or destination hitting a pending load
    always_comb begin
        reg_hit = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            reg_hit = reg_hit || (sb_valid[i] &&
                      (reg_match(dec_i.rs1_re, dec_i.rs1_addr, sb_rd[i]) ||
                       reg_match(dec_i.rs2_re, dec_i.rs2_addr, sb_rd[i]) ||
                       reg_match(dec_i.rd_we,  dec_i.rd_addr,  sb_rd[i])));
        end
    end

    // downward scan so the lowest free entry wins
    always_comb begin
        alloc_id_o = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!sb_valid[i]) begin
                alloc_id_o = ID_W'(i);
            end
        end
    end

    assign sb_full = &sb_valid;

    assign hazard_stall_o = accept_i && (reg_hit || (is_long_i && sb_full));
    assign alloc          = accept_i && !hazard_stall_o && is_long_i;

    // commit and alloc never name the same entry in one cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sb_valid <= '0;
        end else begin
            if (commit_valid_i) begin
                sb_valid[commit_id_i] <= 1'b0;
            end
            if (alloc) begin
                sb_valid[alloc_id_o] <= 1'b1;
            end
        end
    end

    // destination tag of each outstanding load
    always_ff @(posedge clk) begin
        if (alloc) begin
            sb_rd[alloc_id_o] <= dec_i.rd_addr;
        end
    end

endmodule

//--- logic/dispatch_isa_pkg.sv
// Unit select and per-unit operation encodings carried in the decode info bus.
// Referenced by scoped name from RTL and testbench.
package dispatch_isa_pkg;

    // target unit of a decoded instruction
    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_BJP  = 2'd2,
        UNIT_MEM  = 2'd3
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        BJP_JAL  = 3'd0,
        BJP_JALR = 3'd1,
        BJP_BEQ  = 3'd2,
        BJP_BNE  = 3'd3,
        BJP_BLT  = 3'd4,
        BJP_BGE  = 3'd5,
        BJP_BLTU = 3'd6,
        BJP_BGEU = 3'd7
    } bjp_op_e;

    // loads occupy the low codes, stores the top three
    typedef enum logic [2:0] {
        MEM_LB  = 3'd0,
        MEM_LH  = 3'd1,
        MEM_LW  = 3'd2,
        MEM_LBU = 3'd3,
        MEM_LHU = 3'd4,
        MEM_SB  = 3'd5,
        MEM_SH  = 3'd6,
        MEM_SW  = 3'd7
    } mem_op_e;

    // op is sized for the widest unit encoding
    typedef struct packed {
        unit_e                         unit;
        logic [$bits(alu_op_e)-1:0]    op;
        logic                          op1_pc;
        logic                          op2_imm;
    } dec_info_t;

endpackage

//--- logic/dispatch_logic.sv
// Combinational decode of the info bus into ALU, branch and memory requests.
// Also flags the long-latency loads that the hazard unit must track.
`timescale 1ns/100ps
`include "dispatch_settings.svh"

module dispatch_logic (
    input  dispatch_bus_pkg::dec_bus_t  dec_i,
    input  logic [`DISP_XLEN-1:0]       rs1_rdata_i,
    input  logic [`DISP_XLEN-1:0]       rs2_rdata_i,
    output dispatch_bus_pkg::alu_req_t  alu_o,
    output dispatch_bus_pkg::bjp_req_t  bjp_o,
    output dispatch_bus_pkg::mem_req_t  mem_o,
    output logic                        is_long_o
);

    localparam logic [`DISP_XLEN-1:0] PC_STEP = 4;

    dispatch_isa_pkg::unit_e    unit;
    dispatch_isa_pkg::bjp_op_e  bjp_op;
    dispatch_isa_pkg::mem_op_e  mem_op;
    logic [`DISP_XLEN-1:0]      bjp_base;
    logic [`DISP_XLEN-1:0]      mem_addr;
    logic [`DISP_XLEN/8-1:0]    wmask_base;
    logic                       is_mem;
    logic                       is_load;
    logic                       is_store;
    logic                       is_half;
    logic                       is_word;
    logic                       misaligned;

    assign unit   = dec_i.info.unit;
    assign bjp_op = dispatch_isa_pkg::bjp_op_e'(dec_i.info.op[2:0]);
    assign mem_op = dispatch_isa_pkg::mem_op_e'(dec_i.info.op[2:0]);

    // alu operand select
    always_comb begin
        alu_o.req = (unit == dispatch_isa_pkg::UNIT_ALU);
        alu_o.op  = dispatch_isa_pkg::alu_op_e'(dec_i.info.op);
        alu_o.op1 = dec_i.info.op1_pc ? dec_i.pc : rs1_rdata_i;
        alu_o.op2 = dec_i.info.op2_imm ? dec_i.imm : rs2_rdata_i;
    end

    // jalr targets off rs1, every other branch off the pc
    assign bjp_base = (bjp_op == dispatch_isa_pkg::BJP_JALR) ? rs1_rdata_i : dec_i.pc;

    always_comb begin
        bjp_o.req          = (unit == dispatch_isa_pkg::UNIT_BJP);
        bjp_o.op           = bjp_op;
        bjp_o.adder_result = bjp_base + dec_i.imm;
        bjp_o.next_pc      = dec_i.pc + PC_STEP;
        bjp_o.eq           = (rs1_rdata_i == rs2_rdata_i);
        bjp_o.ge_signed    = ($signed(rs1_rdata_i) >= $signed(rs2_rdata_i));
        bjp_o.ge_unsigned  = (rs1_rdata_i >= rs2_rdata_i);
    end

    // memory access classification
    assign is_mem   = (unit == dispatch_isa_pkg::UNIT_MEM);
    assign mem_addr = rs1_rdata_i + dec_i.imm;
    assign is_store = mem_op inside {dispatch_isa_pkg::MEM_SB,
                                     dispatch_isa_pkg::MEM_SH,
                                     dispatch_isa_pkg::MEM_SW};
    assign is_load  = !is_store;
    assign is_half  = mem_op inside {dispatch_isa_pkg::MEM_LH,
                                     dispatch_isa_pkg::MEM_LHU,
                                     dispatch_isa_pkg::MEM_SH};
    assign is_word  = mem_op inside {dispatch_isa_pkg::MEM_LW,
                                     dispatch_isa_pkg::MEM_SW};

    // bytes never misalign
    assign misaligned = (is_half && mem_addr[0]) ||
                        (is_word && (mem_addr[1:0] != 2'b00));

    // byte lanes before the address shift, loads write nothing
    always_comb begin
        case (mem_op)
            dispatch_isa_pkg::MEM_SB: wmask_base = 4'b0001;
            dispatch_isa_pkg::MEM_SH: wmask_base = 4'b0011;
            dispatch_isa_pkg::MEM_SW: wmask_base = 4'b1111;
            default:                  wmask_base = 4'b0000;
        endcase
    end

    always_comb begin
        mem_o.req              = is_mem && !misaligned;
        mem_o.op               = mem_op;
        mem_o.addr             = mem_addr;
        mem_o.wmask            = wmask_base << mem_addr[1:0];
        mem_o.wdata            = rs2_rdata_i << {mem_addr[1:0], 3'b000};
        mem_o.misaligned_load  = is_mem && is_load && misaligned;
        mem_o.misaligned_store = is_mem && is_store && misaligned;
    end

    // an aligned load that writes back holds a scoreboard entry
    assign is_long_o = is_mem && is_load && !misaligned && dec_i.rd_we;

endmodule

//--- logic/dispatch_pipe.sv
// Output register of the dispatch stage.
// Holds under downstream stall, loads a bubble when nothing is accepted.
`timescale 1ns/100ps
`include "dispatch_settings.svh"

module dispatch_pipe (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            stall_i,
    input  logic                            inst_valid_i,
    input  logic                            hazard_i,
    input  dispatch_bus_pkg::dec_bus_t      dec_i,
    input  logic [`DISP_COMMIT_ID_W-1:0]    alloc_id_i,
    input  dispatch_bus_pkg::alu_req_t      alu_i,
    input  dispatch_bus_pkg::bjp_req_t      bjp_i,
    input  dispatch_bus_pkg::mem_req_t      mem_i,
    output dispatch_bus_pkg::issue_t        issue_o,
    output dispatch_bus_pkg::alu_req_t      alu_o,
    output dispatch_bus_pkg::bjp_req_t      bjp_o,
    output dispatch_bus_pkg::mem_req_t      mem_o
);

    logic                           accept;
    logic                           is_load;
    dispatch_bus_pkg::issue_t       issue_d;
    dispatch_bus_pkg::alu_req_t     alu_d;
    dispatch_bus_pkg::bjp_req_t     bjp_d;
    dispatch_bus_pkg::mem_req_t     mem_d;

    assign accept = inst_valid_i && !hazard_i;

    // same condition the hdu allocates on
    assign is_load = mem_i.req && dec_i.rd_we &&
                     (mem_i.op inside {dispatch_isa_pkg::MEM_LB, dispatch_isa_pkg::MEM_LH,
                                       dispatch_isa_pkg::MEM_LW, dispatch_isa_pkg::MEM_LBU,
                                       dispatch_isa_pkg::MEM_LHU});

    // a bubble keeps the payload but drops every flag
    always_comb begin
        issue_d.valid     = accept;
        issue_d.pc        = dec_i.pc;
        issue_d.commit_id = is_load ? alloc_id_i : '0;
        issue_d.rd        = dec_i.rd_addr;
        issue_d.we        = dec_i.rd_we;
        alu_d             = alu_i;
        alu_d.req         = alu_i.req && accept;
        bjp_d             = bjp_i;
        bjp_d.req         = bjp_i.req && accept;
        mem_d             = mem_i;
        mem_d.req              = mem_i.req && accept;
        mem_d.misaligned_load  = mem_i.misaligned_load && accept;
        mem_d.misaligned_store = mem_i.misaligned_store && accept;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_o.valid          <= 1'b0;
            alu_o.req              <= 1'b0;
            bjp_o.req              <= 1'b0;
            mem_o.req              <= 1'b0;
            mem_o.misaligned_load  <= 1'b0;
            mem_o.misaligned_store <= 1'b0;
        end else if (!stall_i) begin
            issue_o <= issue_d;
            alu_o   <= alu_d;
            bjp_o   <= bjp_d;
            mem_o   <= mem_d;
        end
    end

endmodule

//--- logic/dispatch_settings.svh
// Widths and scoreboard sizing for the dispatch stage.
// Included by the bus package and by every RTL module that sizes a port.
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// integer data and address width
`define DISP_XLEN 32

// architectural register index width
`define DISP_REG_ADDR_W 5

// outstanding loads tracked by the hazard unit
`define DISP_SB_DEPTH 4

// one commit id per scoreboard entry
`define DISP_COMMIT_ID_W 2

`endif

//--- run.sh
#!/bin/sh
# Build the dispatch testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f list.f --top-module dispatch_tb -o dispatch_sim

out=$(./obj_dir/dispatch_sim || true)
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
else
    exit 1
fi
